/* Bender.yml */
package:
  name: cl_tst_scrb

sources:
  - scrb_pkg.sv
  - axi_if.sv
  - tst_cfg_regs.sv
  - tst_atg.sv
  - mem_scrb.sv
  - cl_tst_scrb.sv
  - target: test
    files:
      - tb_axi_mem.sv
      - tb_cl_tst_scrb.sv

/* axi_if.sv */
// ******************************
// AXI write bundle (aw, w, b) and read bundle (ar, r)
// ******************************
`timescale 1ns/10ps
`default_nettype none

interface axi_wr_if;
   import scrb_pkg::*;

   logic [id_w-1:0]   awid;
   logic [addr_w-1:0] awaddr;
   logic [7:0]        awlen;
   logic              awvalid;
   logic              awready;

   logic [data_w-1:0] wdata;
   logic [strb_w-1:0] wstrb;
   logic              wlast;
   logic              wvalid;
   logic              wready;

   logic [id_w-1:0]   bid;
   logic [1:0]        bresp;
   logic              bvalid;
   logic              bready;

   modport master (
      output awid, awaddr, awlen, awvalid, wdata, wstrb, wlast, wvalid, bready,
      input  awready, wready, bid, bresp, bvalid
   );

   modport slave (
      input  awid, awaddr, awlen, awvalid, wdata, wstrb, wlast, wvalid, bready,
      output awready, wready, bid, bresp, bvalid
   );
endinterface

interface axi_rd_if;
   import scrb_pkg::*;

   logic [id_w-1:0]   arid;
   logic [addr_w-1:0] araddr;
   logic [7:0]        arlen;
   logic              arvalid;
   logic              arready;

   logic [id_w-1:0]   rid;
   logic [data_w-1:0] rdata;
   logic [1:0]        rresp;
   logic              rlast;
   logic              rvalid;
   logic              rready;

   modport master (
      output arid, araddr, arlen, arvalid, rready,
      input  arready, rid, rdata, rresp, rlast, rvalid
   );

   modport slave (
      input  arid, araddr, arlen, arvalid, rready,
      output arready, rid, rdata, rresp, rlast, rvalid
   );
endinterface

`default_nettype wire

/* cl_tst_scrb.sv */
// ******************************
// memory test top with the ATG, the scrubber and the port mux
// ******************************
`timescale 1ns/10ps
`default_nettype none

module cl_tst_scrb (
   input  logic                        clk,
   input  logic                        rst_n,

   input  logic [31:0]                 cfg_addr,
   input  logic [scrb_pkg::data_w-1:0] cfg_wdata,
   input  logic                        cfg_wr,
   input  logic                        cfg_rd,
   output logic                        tst_cfg_ack,
   output logic [scrb_pkg::data_w-1:0] tst_cfg_rdata,

   input  logic                        scrb_enable,
   output logic                        scrb_done,
   output logic [2:0]                  scrb_dbg_state,
   output logic [scrb_pkg::addr_w-1:0] scrb_dbg_addr,

   output logic [scrb_pkg::id_w-1:0]   awid,
   output logic [scrb_pkg::addr_w-1:0] awaddr,
   output logic [7:0]                  awlen,
   output logic                        awvalid,
   input  logic                        awready,
   output logic [scrb_pkg::data_w-1:0] wdata,
   output logic [scrb_pkg::strb_w-1:0] wstrb,
   output logic                        wlast,
   output logic                        wvalid,
   input  logic                        wready,
   input  logic [scrb_pkg::id_w-1:0]   bid,
   input  logic [1:0]                  bresp,
   input  logic                        bvalid,
   output logic                        bready,

   output logic [scrb_pkg::id_w-1:0]   arid,
   output logic [scrb_pkg::addr_w-1:0] araddr,
   output logic [7:0]                  arlen,
   output logic                        arvalid,
   input  logic                        arready,
   input  logic [scrb_pkg::id_w-1:0]   rid,
   input  logic [scrb_pkg::data_w-1:0] rdata,
   input  logic [1:0]                  rresp,
   input  logic                        rlast,
   input  logic                        rvalid,
   output logic                        rready
);
   import scrb_pkg::*;

   logic              start_wr;
   logic              start_rd;
   logic [addr_w-1:0] base;
   logic [7:0]        nburst;
   logic [data_w-1:0] seed;
   logic              busy;
   logic              done;
   logic [err_w-1:0]  err_cnt;

   axi_wr_if atg_wr ();
   axi_wr_if scrb_wr ();
   axi_rd_if atg_rd ();

   tst_cfg_regs cfg_regs_i (
      .clk, .rst_n,
      .cfg_addr, .cfg_wdata, .cfg_wr, .cfg_rd, .tst_cfg_ack, .tst_cfg_rdata,
      .start_wr, .start_rd, .base, .nburst, .seed, .busy, .done, .err_cnt
   );

   tst_atg atg_i (
      .clk, .rst_n,
      .start_wr, .start_rd, .base, .nburst, .seed, .busy, .done, .err_cnt,
      .wr (atg_wr.master),
      .rd (atg_rd.master)
   );

   mem_scrb scrb_i (
      .clk, .rst_n,
      .scrb_enable,
      .scrb_done,
      .dbg_state (scrb_dbg_state),
      .dbg_addr  (scrb_dbg_addr),
      .wr        (scrb_wr.master)
   );

   // the write port belongs to the scrubber for as long as scrb_enable is high
   assign awid    = scrb_enable ? scrb_wr.awid    : atg_wr.awid;
   assign awaddr  = scrb_enable ? scrb_wr.awaddr  : atg_wr.awaddr;
   assign awlen   = scrb_enable ? scrb_wr.awlen   : atg_wr.awlen;
   assign awvalid = scrb_enable ? scrb_wr.awvalid : atg_wr.awvalid;
   assign wdata   = scrb_enable ? scrb_wr.wdata   : atg_wr.wdata;
   assign wstrb   = scrb_enable ? scrb_wr.wstrb   : atg_wr.wstrb;
   assign wlast   = scrb_enable ? scrb_wr.wlast   : atg_wr.wlast;
   assign wvalid  = scrb_enable ? scrb_wr.wvalid  : atg_wr.wvalid;
   assign bready  = scrb_enable ? scrb_wr.bready  : atg_wr.bready;

   assign atg_wr.awready  = ~scrb_enable & awready;
   assign scrb_wr.awready =  scrb_enable & awready;
   assign atg_wr.wready   = ~scrb_enable & wready;
   assign scrb_wr.wready  =  scrb_enable & wready;
   assign atg_wr.bvalid   = ~scrb_enable & bvalid;
   assign scrb_wr.bvalid  =  scrb_enable & bvalid;
   assign atg_wr.bid      = bid;
   assign atg_wr.bresp    = bresp;
   assign scrb_wr.bid     = bid;
   assign scrb_wr.bresp   = bresp;

   // ATG reads are fenced off in both directions during a scrub, so no beat goes unseen
   assign arid    = atg_rd.arid;
   assign araddr  = atg_rd.araddr;
   assign arlen   = atg_rd.arlen;
   assign arvalid = ~scrb_enable & atg_rd.arvalid;
   assign rready  = ~scrb_enable & atg_rd.rready;

   assign atg_rd.arready = ~scrb_enable & arready;
   assign atg_rd.rvalid  = ~scrb_enable & rvalid;
   assign atg_rd.rid     = rid;
   assign atg_rd.rdata   = rdata;
   assign atg_rd.rresp   = rresp;
   assign atg_rd.rlast   = rlast;

endmodule

`default_nettype wire

/* mem_scrb.sv */
// ******************************
// memory scrubber, zero fill of the low region
// ******************************
`timescale 1ns/10ps
`default_nettype none

module mem_scrb (
   input  logic                        clk,
   input  logic                        rst_n,

   input  logic                        scrb_enable,
   output logic                        scrb_done,
   output scrb_pkg::scrb_state_t       dbg_state,
   output logic [scrb_pkg::addr_w-1:0] dbg_addr,

   axi_wr_if.master                    wr
);
   import scrb_pkg::*;

   scrb_state_t       state;
   logic [addr_w-1:0] cur_addr;
   logic [beat_w-1:0] beat_cnt;

   assign scrb_done = (state == scrb_end);
   assign dbg_state = state;
   assign dbg_addr  = cur_addr;

   assign wr.awid    = scrb_id;
   assign wr.awaddr  = cur_addr;
   assign wr.awlen   = axi_len;
   assign wr.awvalid = (state == scrb_aw);
   assign wr.wdata   = '0;
   assign wr.wstrb   = '1;
   assign wr.wlast   = (beat_cnt == beat_w'(burst_len - 1));
   assign wr.wvalid  = (state == scrb_w);
   assign wr.bready  = (state == scrb_b);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= scrb_idle;
         cur_addr <= '0;
         beat_cnt <= '0;
      end else if (!scrb_enable) begin
         // dropping the enable abandons the pass, the next one starts from word 0
         state    <= scrb_idle;
         cur_addr <= '0;
         beat_cnt <= '0;
      end else begin
         case (state)
            scrb_idle: state <= scrb_aw;
            scrb_aw: begin
               if (wr.awready)
                  state <= scrb_w;
            end
            scrb_w: begin
               if (wr.wready) begin
                  cur_addr <= cur_addr + addr_w'(strb_w);
                  beat_cnt <= beat_cnt + 1'b1;
                  if (wr.wlast) begin
                     beat_cnt <= '0;
                     state    <= scrb_b;
                  end
               end
            end
            scrb_b: begin
               if (wr.bvalid)
                  state <= (cur_addr == scrb_end_addr) ? scrb_end : scrb_aw;
            end
            scrb_end: state <= scrb_end;  // held until the enable drops
            default:  state <= scrb_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

/* scrb_pkg.sv */
// ******************************
// sizes, cfg register map, FSM state enums and the test data pattern
// ******************************
`default_nettype none

package scrb_pkg;

   localparam int data_w    = 32;
   localparam int addr_w    = 32;
   localparam int id_w      = 4;
   localparam int strb_w    = data_w / 8;  // bytes per beat
   localparam int err_w     = 16;
   localparam int burst_len = 4;
   localparam int beat_w    = $clog2(burst_len);

   // length field of aw and ar carries beats minus one
   localparam logic [7:0] axi_len = 8'(burst_len - 1);

   localparam logic [id_w-1:0] atg_id  = id_w'(1);
   localparam logic [id_w-1:0] scrb_id = id_w'(2);

   localparam int scrb_max_word = 255;
   // first byte address past the scrubbed region
   localparam logic [addr_w-1:0] scrb_end_addr = addr_w'((scrb_max_word + 1) * strb_w);

   localparam logic [data_w-1:0] bad_reg_val = 32'hdead_beef;

   typedef enum logic [2:0] {
      reg_ctl    = 3'd0,  // bit 0 starts writes, bit 1 starts reads
      reg_base   = 3'd1,
      reg_nburst = 3'd2,
      reg_seed   = 3'd3,
      reg_status = 3'd4   // read only
   } cfg_reg_t;

   typedef enum logic [2:0] {
      atg_idle,
      atg_aw,
      atg_w,
      atg_b,
      atg_ar,
      atg_r
   } atg_state_t;

   typedef enum logic [2:0] {
      scrb_idle,
      scrb_aw,
      scrb_w,
      scrb_b,
      scrb_end
   } scrb_state_t;

   // the word at byte address addr holds seed plus the word index, wrapping at 2^32
   function automatic logic [data_w-1:0] atg_pattern(input logic [data_w-1:0] seed,
                                                     input logic [addr_w-1:0] addr);
      return seed + data_w'(addr / strb_w);
   endfunction

endpackage

`default_nettype wire

/* tb_axi_mem.sv */
// ******************************
// AXI memory model with random stalls and a word corruption hook
// ******************************
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        stall_en,

   input  logic [scrb_pkg::id_w-1:0]   awid,
   input  logic [scrb_pkg::addr_w-1:0] awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [scrb_pkg::data_w-1:0] wdata,
   input  logic                        wlast,
   input  logic                        wvalid,
   output logic                        wready,
   output logic [scrb_pkg::id_w-1:0]   bid,
   output logic [1:0]                  bresp,
   output logic                        bvalid,
   input  logic                        bready,

   input  logic [scrb_pkg::id_w-1:0]   arid,
   input  logic [scrb_pkg::addr_w-1:0] araddr,
   input  logic [7:0]                  arlen,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [scrb_pkg::id_w-1:0]   rid,
   output logic [scrb_pkg::data_w-1:0] rdata,
   output logic [1:0]                  rresp,
   output logic                        rlast,
   output logic                        rvalid,
   input  logic                        rready
);
   import scrb_pkg::*;

   localparam int depth = 1024;

   logic [data_w-1:0] mem [depth];
   logic [31:0]       lfsr = 32'h2d392144;
   logic [4:0]        go = '1;  // awready, wready, bvalid, arready, rvalid
   logic              wr_busy;
   logic              b_pend;
   logic [9:0]        wr_idx;
   logic              rd_busy;
   logic [9:0]        rd_idx;
   logic [7:0]        rd_left;

   // Fibonacci form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic corrupt_word(input logic [9:0] idx);
      mem[idx] = ~mem[idx];
   endtask

   initial begin
      for (int i = 0; i < depth; i++)
         mem[i] = 32'hf00d_0000 + i;
   end

   // one LFSR step for every stall bit that is drawn
   always @(posedge clk) begin
      if (stall_en) begin
         for (int k = 0; k < 5; k++) begin
            lfsr = lfsr_step(lfsr);
            go[k] <= lfsr[0];
         end
      end else begin
         go <= '1;
      end
   end

   assign awready = !wr_busy && !b_pend && go[0];
   assign wready  = wr_busy && go[1];
   assign bresp   = 2'b00;
   assign arready = !rd_busy && go[3];
   assign rresp   = 2'b00;

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_busy <= 1'b0;
         b_pend  <= 1'b0;
         bvalid  <= 1'b0;
         wr_idx  <= '0;
         bid     <= '0;
      end else begin
         if (awvalid && awready) begin
            wr_busy <= 1'b1;
            wr_idx  <= awaddr[11:2];  // word index wraps at the memory size
            bid     <= awid;
         end
         if (wvalid && wready) begin
            mem[wr_idx] <= wdata;
            wr_idx      <= wr_idx + 10'd1;
            if (wlast) begin
               wr_busy <= 1'b0;
               b_pend  <= 1'b1;
            end
         end
         if (b_pend && !bvalid && go[2])
            bvalid <= 1'b1;
         if (bvalid && bready) begin
            bvalid <= 1'b0;
            b_pend <= 1'b0;
         end
      end
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_busy <= 1'b0;
         rvalid  <= 1'b0;
         rlast   <= 1'b0;
         rd_idx  <= '0;
         rd_left <= '0;
         rid     <= '0;
         rdata   <= '0;
      end else begin
         if (arvalid && arready) begin
            rd_busy <= 1'b1;
            rd_idx  <= araddr[11:2];
            rd_left <= arlen;
            rid     <= arid;
         end
         // the beat is loaded when rvalid rises and held until it is taken
         if (rd_busy && !rvalid && go[4]) begin
            rvalid <= 1'b1;
            rdata  <= mem[rd_idx];
            rlast  <= (rd_left == 8'd0);
         end
         if (rvalid && rready) begin
            rvalid  <= 1'b0;
            rd_idx  <= rd_idx + 10'd1;
            rd_left <= rd_left - 8'd1;
            if (rlast)
               rd_busy <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* tb_cl_tst_scrb.sv */
// ******************************
// testbench for the memory test top driven by commands from tb_input.txt
// ******************************
`timescale 1ns/10ps
`default_nettype none

module tb_cl_tst_scrb;
   import scrb_pkg::*;

   localparam logic [31:0] status_addr = 32'h10;
   localparam int ack_limit  = 8;
   localparam int poll_limit = 4000;   // status reads
   localparam int scrb_limit = 20000;  // cycles

   logic              clk = 1'b0;
   logic              rst_n;
   logic              stall_en;
   logic [31:0]       cfg_addr;
   logic [data_w-1:0] cfg_wdata;
   logic              cfg_wr;
   logic              cfg_rd;
   logic              tst_cfg_ack;
   logic [data_w-1:0] tst_cfg_rdata;
   logic              scrb_enable;
   logic              scrb_done;
   logic [2:0]        scrb_dbg_state;
   logic [addr_w-1:0] scrb_dbg_addr;
   logic [id_w-1:0]   awid;
   logic [addr_w-1:0] awaddr;
   logic [7:0]        awlen;
   logic              awvalid;
   logic              awready;
   logic [data_w-1:0] wdata;
   logic [strb_w-1:0] wstrb;
   logic              wlast;
   logic              wvalid;
   logic              wready;
   logic [id_w-1:0]   bid;
   logic [1:0]        bresp;
   logic              bvalid;
   logic              bready;
   logic [id_w-1:0]   arid;
   logic [addr_w-1:0] araddr;
   logic [7:0]        arlen;
   logic              arvalid;
   logic              arready;
   logic [id_w-1:0]   rid;
   logic [data_w-1:0] rdata;
   logic [1:0]        rresp;
   logic              rlast;
   logic              rvalid;
   logic              rready;

   int          errors = 0;
   int          timeouts = 0;
   logic        stop_run = 1'b0;
   logic [31:0] exp_seed = '0;  // last seed written to the seed register

   always #5 clk = ~clk;

   cl_tst_scrb dut_i (.*);

   tb_axi_mem mem_i (.*);

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Fail %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // AXI request fields that the memory model ignores
   always @(posedge clk) begin
      if (rst_n && awvalid) begin
         check_value("awlen", awlen, 32'd3);
         check_value("awid", awid, scrb_enable ? 32'd2 : 32'd1);
      end
      if (rst_n && wvalid)
         check_value("wstrb", wstrb, 32'hf);
      if (rst_n && arvalid) begin
         check_value("arlen", arlen, 32'd3);
         check_value("arid", arid, 32'd1);
      end
   end

   // called right after a falling edge and returns right after one
   task automatic cfg_access(input logic is_wr, input logic [31:0] addr,
                             input logic [31:0] data, output logic [31:0] rd_val);
      int n;
      n = 0;
      rd_val = '0;
      cfg_addr  = addr;
      cfg_wdata = data;
      cfg_wr    = is_wr;
      cfg_rd    = !is_wr;
      @(negedge clk);
      cfg_wr = 1'b0;
      cfg_rd = 1'b0;
      while (!tst_cfg_ack && n < ack_limit) begin
         @(negedge clk);
         n++;
      end
      if (!tst_cfg_ack) begin
         $display("timeout: no ack on the cfg bus for address %h", addr);
         timeouts++;
         stop_run = 1'b1;
      end else begin
         check_value("tst_cfg_ack delay", n, 32'd0);  // due in the cycle after the strobe
         rd_val = tst_cfg_rdata;
         @(negedge clk);
         check_value("tst_cfg_ack", tst_cfg_ack, 32'd0);  // one cycle wide
      end
   endtask

   task automatic wait_atg_done(input logic [31:0] exp_status);
      logic [31:0] status;
      int n;
      n = 0;
      status = '0;
      while (!status[1] && n < poll_limit && !stop_run) begin
         cfg_access(1'b0, status_addr, '0, status);
         n++;
      end
      if (status[1])
         check_value("reg_status", status, exp_status);
      else if (!stop_run) begin
         $display("timeout: the traffic generator never reported done");
         timeouts++;
         stop_run = 1'b1;
      end
   endtask

   task automatic wait_scrb_done(input logic level);
      int n;
      n = 0;
      while (scrb_done !== level && n < scrb_limit) begin
         @(negedge clk);
         n++;
      end
      if (scrb_done !== level) begin
         $display("timeout: scrb_done did not go to %0d", level);
         timeouts++;
         stop_run = 1'b1;
      end else begin
         // a finished pass rests past word 255 and an idle scrubber at word 0
         check_value("scrb_dbg_state", scrb_dbg_state, level ? 32'd4 : 32'd0);
         check_value("scrb_dbg_addr", scrb_dbg_addr, level ? 32'h400 : 32'h0);
      end
   endtask

   task automatic check_window(input logic [31:0] first, input logic [31:0] count);
      for (int i = 0; i < count; i++)
         check_value($sformatf("mem[%0d]", first + i), mem_i.mem[10'(first + i)],
                     exp_seed + first + i);
   endtask

   task automatic run_command(input logic [7:0] cmd, input logic [31:0] a,
                              input logic [31:0] b);
      logic [31:0] rd_val;
      case (cmd)
         "W": begin
            cfg_access(1'b1, a, b, rd_val);
            if (a == 32'hc)
               exp_seed = b;
         end
         "R": begin
            cfg_access(1'b0, a, '0, rd_val);
            if (!stop_run)
               check_value($sformatf("tst_cfg_rdata at %h", a), rd_val, b);
         end
         "D": wait_atg_done(a);
         "S": scrb_enable = a[0];
         "Z": wait_scrb_done(a[0]);
         "C": mem_i.corrupt_word(a[9:0]);
         "M": check_value($sformatf("mem[%0d]", a), mem_i.mem[a[9:0]], b);
         "A": check_window(a, b);
         "T": stall_en = a[0];
         "N": repeat (a) @(negedge clk);
         default: begin
            $display("unknown command %c in tb_input.txt", cmd);
            errors++;
         end
      endcase
   endtask

   initial begin : main_seq
      int fd;
      int cnt;
      int ch;
      logic [7:0] cmd;
      logic [31:0] a;
      logic [31:0] b;
      rst_n       = 1'b0;
      stall_en    = 1'b0;
      cfg_addr    = '0;
      cfg_wdata   = '0;
      cfg_wr      = 1'b0;
      cfg_rd      = 1'b0;
      scrb_enable = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_value("awvalid", awvalid, 32'd0);
      check_value("wvalid", wvalid, 32'd0);
      check_value("arvalid", arvalid, 32'd0);
      check_value("bready", bready, 32'd0);
      check_value("rready", rready, 32'd0);
      check_value("scrb_done", scrb_done, 32'd0);
      check_value("scrb_dbg_state", scrb_dbg_state, 32'd0);
      check_value("tst_cfg_ack", tst_cfg_ack, 32'd0);

      fd = $fopen("tb_input.txt", "r");
      if (fd == 0) begin
         $display("could not open tb_input.txt");
         errors++;
      end else begin
         while (!stop_run && !$feof(fd)) begin
            cnt = $fscanf(fd, " %c", cmd);
            if (cnt == 1) begin
               if (cmd == "#") begin
                  ch = $fgetc(fd);
                  while (ch != 10 && ch != -1)
                     ch = $fgetc(fd);
               end else begin
                  a = '0;
                  b = '0;
                  cnt = $fscanf(fd, "%h %h", a, b);
                  run_command(cmd, a, b);
               end
            end
         end
         $fclose(fd);
      end

      $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

/* tb_input.txt */
# cmd a b in hex: W addr data, R addr expect, D status expect, A first_word count, M word expect
# C word, S level, Z level, T stalls, N cycles; unused fields are 0
R 10 0
R 0 0
W 4 0
W 8 10
W c 12340000
R 4 0
R 8 10
R c 12340000
R 14 deadbeef
R 100 deadbeef
W 0 1
D 2 0
A 0 40
W 0 2
D 2 0
C 5 0
C 3a 0
W 0 2
D 20002 0
W 4 300
W 8 20
W c 50000000
W 0 1
D 20002 0
A c0 80
S 1 0
Z 1 0
M 0 0
M ff 0
M 100 50000100
W 4 0
W 8 1
W c 77000000
W 0 1
N 40 0
R 10 20001
M 0 0
S 0 0
Z 0 0
D 20002 0
A 0 4
T 1 0
W 4 0
W 8 50
W c abc0000
W 0 1
D 20002 0
A 0 140
W 0 2
D 2 0
C 10 0
C 120 0
W 0 2
D 20002 0
S 1 0
Z 1 0
M 0 0
M ff 0
M 100 abc0100
W 4 40
W 8 2
W c def0000
W 0 1
N 40 0
R 10 20001
M 10 0
S 0 0
Z 0 0
D 20002 0
A 10 8

/* tst_atg.sv */
// ******************************
// traffic generator, write bursts then read and compare
// ******************************
`timescale 1ns/10ps
`default_nettype none

module tst_atg (
   input  logic                        clk,
   input  logic                        rst_n,

   input  logic                        start_wr,
   input  logic                        start_rd,
   input  logic [scrb_pkg::addr_w-1:0] base,
   input  logic [7:0]                  nburst,
   input  logic [scrb_pkg::data_w-1:0] seed,
   output logic                        busy,
   output logic                        done,
   output logic [scrb_pkg::err_w-1:0]  err_cnt,

   axi_wr_if.master                    wr,
   axi_rd_if.master                    rd
);
   import scrb_pkg::*;

   atg_state_t        state;
   logic [addr_w-1:0] cur_addr;  // byte address of the next beat
   logic [7:0]        burst_cnt;
   logic [beat_w-1:0] beat_cnt;
   logic              last_burst;
   logic              beat_bad;

   assign last_burst = (burst_cnt == nburst - 8'd1);
   assign beat_bad   = (rd.rdata != atg_pattern(seed, cur_addr)) || (rd.rresp != 2'b00);
   assign busy       = (state != atg_idle);

   // payload comes straight from the held address, so it stays put under back-pressure
   assign wr.awid    = atg_id;
   assign wr.awaddr  = cur_addr;
   assign wr.awlen   = axi_len;
   assign wr.awvalid = (state == atg_aw);
   assign wr.wdata   = atg_pattern(seed, cur_addr);
   assign wr.wstrb   = '1;
   assign wr.wlast   = (beat_cnt == beat_w'(burst_len - 1));
   assign wr.wvalid  = (state == atg_w);
   assign wr.bready  = (state == atg_b);

   assign rd.arid    = atg_id;
   assign rd.araddr  = cur_addr;
   assign rd.arlen   = axi_len;
   assign rd.arvalid = (state == atg_ar);
   assign rd.rready  = (state == atg_r);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= atg_idle;
         done      <= 1'b0;
         err_cnt   <= '0;
         cur_addr  <= '0;
         burst_cnt <= '0;
         beat_cnt  <= '0;
      end else begin
         case (state)
            atg_idle: begin
               if (start_wr || start_rd) begin
                  cur_addr  <= base;
                  burst_cnt <= '0;
                  beat_cnt  <= '0;
                  done      <= (nburst == 8'd0);  // an empty window finishes at once
                  if (nburst != 8'd0)
                     state <= start_wr ? atg_aw : atg_ar;
               end
               if (start_rd && !start_wr)
                  err_cnt <= '0;
            end
            atg_aw: begin
               if (wr.awready)
                  state <= atg_w;
            end
            atg_w: begin
               if (wr.wready) begin
                  cur_addr <= cur_addr + addr_w'(strb_w);
                  beat_cnt <= beat_cnt + 1'b1;
                  if (wr.wlast) begin
                     beat_cnt <= '0;
                     state    <= atg_b;
                  end
               end
            end
            atg_b: begin
               if (wr.bvalid) begin
                  burst_cnt <= burst_cnt + 8'd1;
                  if (last_burst) begin
                     state <= atg_idle;
                     done  <= 1'b1;
                  end else begin
                     state <= atg_aw;
                  end
               end
            end
            atg_ar: begin
               if (rd.arready)
                  state <= atg_r;
            end
            atg_r: begin
               if (rd.rvalid) begin
                  cur_addr <= cur_addr + addr_w'(strb_w);
                  if (beat_bad && (err_cnt != '1))
                     err_cnt <= err_cnt + 1'b1;  // saturates at all ones
                  if (rd.rlast) begin
                     burst_cnt <= burst_cnt + 8'd1;
                     if (last_burst) begin
                        state <= atg_idle;
                        done  <= 1'b1;
                     end else begin
                        state <= atg_ar;
                     end
                  end
               end
            end
            default: state <= atg_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

/* tst_cfg_regs.sv */
// ******************************
// cfg register block for the traffic generator
// ******************************
`timescale 1ns/10ps
`default_nettype none

module tst_cfg_regs (
   input  logic                        clk,
   input  logic                        rst_n,

   input  logic [31:0]                 cfg_addr,
   input  logic [scrb_pkg::data_w-1:0] cfg_wdata,
   input  logic                        cfg_wr,
   input  logic                        cfg_rd,
   output logic                        tst_cfg_ack,
   output logic [scrb_pkg::data_w-1:0] tst_cfg_rdata,

   output logic                        start_wr,
   output logic                        start_rd,
   output logic [scrb_pkg::addr_w-1:0] base,
   output logic [7:0]                  nburst,
   output logic [scrb_pkg::data_w-1:0] seed,
   input  logic                        busy,
   input  logic                        done,
   input  logic [scrb_pkg::err_w-1:0]  err_cnt
);
   import scrb_pkg::*;

   cfg_reg_t          reg_sel;
   logic              addr_ok;
   logic              ctl_wr;
   logic [data_w-1:0] rd_val;

   // cfg_addr is a byte address and the registers sit on word boundaries
   assign reg_sel = cfg_reg_t'(cfg_addr[4:2]);
   assign addr_ok = (cfg_addr[31:5] == '0) && (cfg_addr[1:0] == 2'b00);
   assign ctl_wr  = cfg_wr && addr_ok && (reg_sel == reg_ctl);

   always_comb begin
      rd_val = bad_reg_val;
      if (addr_ok) begin
         case (reg_sel)
            reg_ctl:    rd_val = '0;  // start bits clear themselves
            reg_base:   rd_val = base;
            reg_nburst: rd_val = data_w'(nburst);
            reg_seed:   rd_val = seed;
            reg_status: rd_val = {err_cnt, 14'd0, done, busy};
            default:    rd_val = bad_reg_val;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tst_cfg_ack <= 1'b0;
         start_wr    <= 1'b0;
         start_rd    <= 1'b0;
         base        <= '0;
         nburst      <= '0;
         seed        <= '0;
      end else begin
         tst_cfg_ack <= cfg_wr | cfg_rd;
         start_wr    <= ctl_wr & cfg_wdata[0];
         start_rd    <= ctl_wr & cfg_wdata[1];
         if (cfg_wr && addr_ok) begin
            case (reg_sel)
               reg_base:   base   <= cfg_wdata;  // software keeps this burst aligned
               reg_nburst: nburst <= cfg_wdata[7:0];
               reg_seed:   seed   <= cfg_wdata;
               default:    ;
            endcase
         end
      end
   end

   // status is sampled with the read strobe and shows up together with the ack
   always_ff @(posedge clk) begin
      if (cfg_rd)
         tst_cfg_rdata <= rd_val;
   end

endmodule

`default_nettype wire

/* vlog.f */
scrb_pkg.sv
axi_if.sv
tst_cfg_regs.sv
tst_atg.sv
mem_scrb.sv
cl_tst_scrb.sv
tb_axi_mem.sv
tb_cl_tst_scrb.sv
